// ==== build.f ====
+incdir+include
verilog/beam_pkg.sv
verilog/thresh_cfg_if.sv
verilog/beam_power.sv
verilog/threshold_detect.sv
verilog/beam_axil_regs.sv
verilog/dual_beam_trigger.sv
tests/tb_dual_beam_trigger.sv

// ==== include/beam_params.svh ====
`ifndef BEAM_PARAMS_SVH
`define BEAM_PARAMS_SVH

// beam geometry
`define BEAM_NCHAN      8
`define BEAM_NSAMP      8
`define BEAM_NBITS      5
// channel index outermost, sample index inside it
`define BEAM_IN_W       320

// datapath widths
`define BEAM_THRESH_W   18
// beam input sampled -> trigger_o
`define BEAM_PIPE_LAT   5

// AXI4-Lite register map, byte offsets
`define BEAM_AXI_AW         5
`define BEAM_REG_THRESH_A   5'h00
`define BEAM_REG_THRESH_B   5'h04
`define BEAM_REG_CTRL       5'h08
`define BEAM_REG_COUNT_A    5'h0C
`define BEAM_REG_COUNT_B    5'h10

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the dual beam trigger testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module tb_dual_beam_trigger \
    -f build.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '>>> FAIL' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q '>>> PASS' sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi

// ==== tests/tb_dual_beam_trigger.sv ====
`timescale 1ns/1ps
`include "beam_params.svh"

module tb_dual_beam_trigger ();

    localparam int TIMEOUT = 50;
    localparam int CONST   = 0;
    localparam int RAND    = 1;
    // threshold as a plain value, or as model power plus an offset
    localparam int ABS     = 0;
    localparam int REL     = 1;
    localparam int THR_MAX = (1 << `BEAM_THRESH_W) - 1;
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;
    localparam int HOLD_CLKS = 7;

    typedef struct packed {
        int mode_a;
        int code_a;
        int mode_b;
        int code_b;
        int tsel_a;
        int tval_a;
        int tsel_b;
        int tval_b;
    } row_t;

    localparam int NROWS = 7;
    localparam row_t ROWS [NROWS] = '{
        // A at full power over 100000, B near zero under 200
        '{CONST, 0,  CONST, 16, ABS, 100000, ABS, 200},
        // A near zero just over 127, B full power equal to its threshold
        '{CONST, 15, CONST, 0,  ABS, 127,    ABS, 123008},
        // random codes at the boundary, equal and one below
        '{RAND,  0,  RAND,  0,  REL, 0,      REL, -1},
        '{RAND,  0,  RAND,  0,  REL, -1,     REL, 0},
        '{CONST, 0,  CONST, 0,  REL, 0,      ABS, 0},
        // all 31 codes give the top centred value +124
        '{RAND,  0,  CONST, 31, ABS, 0,      ABS, 123007},
        '{CONST, 16, RAND,  0,  ABS, THR_MAX, REL, 1}
    };

    logic                    clk = 1'b0;
    logic                    rst;
    logic [`BEAM_IN_W-1:0]   beam_a;
    logic [`BEAM_IN_W-1:0]   beam_b;
    logic [`BEAM_AXI_AW-1:0] awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [31:0]             wdata;
    logic [3:0]              wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [`BEAM_AXI_AW-1:0] araddr;
    logic                    arvalid;
    logic                    arready;
    logic [31:0]             rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;
    logic [1:0]              trigger;

    // 100 ns period
    always #50 clk = ~clk;

    dual_beam_trigger DUT (
        .clk_i(clk), .rst_i(rst), .beam_a_i(beam_a), .beam_b_i(beam_b),
        .s_axil_awaddr_i(awaddr), .s_axil_awvalid_i(awvalid), .s_axil_awready_o(awready),
        .s_axil_wdata_i(wdata), .s_axil_wstrb_i(wstrb), .s_axil_wvalid_i(wvalid),
        .s_axil_wready_o(wready),
        .s_axil_bresp_o(bresp), .s_axil_bvalid_o(bvalid), .s_axil_bready_i(bready),
        .s_axil_araddr_i(araddr), .s_axil_arvalid_i(arvalid), .s_axil_arready_o(arready),
        .s_axil_rdata_o(rdata), .s_axil_rresp_o(rresp), .s_axil_rvalid_o(rvalid),
        .s_axil_rready_i(rready),
        .trigger_o(trigger)
    );

    //////////////////////////////////////////////////////////////////////
    // reporting and clock steps
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // inputs always change 1 ns after the rising edge
    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    task automatic tick_or_timeout(inout int n, input string what);
        step_clock();
        n++;
        if (n > TIMEOUT) begin
            abort_run({"timeout while waiting for ", what});
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI4-Lite master
    //////////////////////////////////////////////////////////////////////

    task automatic axil_write(input logic [`BEAM_AXI_AW-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        // readies are stable between edges, so the handshake lands on the next edge
        while (!(awready && wready)) begin
            tick_or_timeout(n, "write address and data ready");
        end
        step_clock();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n = 0;
        while (!bvalid) begin
            tick_or_timeout(n, "write response");
        end
        resp = bresp;
        step_clock();
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [`BEAM_AXI_AW-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready) begin
            tick_or_timeout(n, "read address ready");
        end
        step_clock();
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        while (!rvalid) begin
            tick_or_timeout(n, "read data");
        end
        data = rdata;
        resp = rresp;
        step_clock();
        rready = 1'b0;
    endtask

    task automatic write_reg(input logic [`BEAM_AXI_AW-1:0] addr, input int data,
                             input logic [1:0] exp_resp);
        logic [1:0] resp;
        axil_write(addr, 32'(data), resp);
        check_value("bresp", 32'(resp), 32'(exp_resp));
    endtask

    task automatic read_check(input logic [`BEAM_AXI_AW-1:0] addr, input int exp_data,
                              input logic [1:0] exp_resp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        check_value({name, " rresp"}, 32'(resp), 32'(exp_resp));
        check_value({name, " rdata"}, data, 32'(exp_data));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    //////////////////////////////////////////////////////////////////////

    // all 64 codes constant, or drawn from the seeded generator
    function automatic logic [`BEAM_IN_W-1:0] make_beam(input int mode, input int code);
        logic [`BEAM_IN_W-1:0] v;
        int rnd;
        for (int i = 0; i < `BEAM_NCHAN * `BEAM_NSAMP; i++) begin
            rnd = $urandom;
            v[i*`BEAM_NBITS +: `BEAM_NBITS] = (mode == RAND) ? rnd[4:0] : code[4:0];
        end
        return v;
    endfunction

    // offset binary: 8 codes sum to 124 at zero signal
    function automatic int model_power(input logic [`BEAM_IN_W-1:0] v);
        int sum;
        int p;
        p = 0;
        for (int s = 0; s < `BEAM_NSAMP; s++) begin
            sum = 0;
            for (int c = 0; c < `BEAM_NCHAN; c++) begin
                sum = sum + 32'(v[`BEAM_NBITS*(`BEAM_NSAMP*c + s) +: `BEAM_NBITS]);
            end
            sum = sum - 124;
            p = p + sum * sum;
        end
        return p;
    endfunction

    function automatic int pick_thresh(input int sel, input int val, input int power);
        int t;
        t = (sel == REL) ? power + val : val;
        if (t < 0) t = 0;
        if (t > THR_MAX) t = THR_MAX;
        return t;
    endfunction

    initial begin
        logic [`BEAM_IN_W-1:0] va;
        logic [`BEAM_IN_W-1:0] vb;
        int                    pa;
        int                    pb;
        int                    ta;
        int                    tb;
        logic [1:0]            exp_trig;

        void'($urandom(20));
        rst     = 1'b1;
        beam_a  = make_beam(CONST, 0);
        beam_b  = make_beam(CONST, 0);
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // full power in, all-ones thresholds, nothing fires
        for (int i = 0; i < 12; i++) begin
            step_clock();
            check_value("trigger_o", 32'(trigger), 32'h0);
        end
        read_check(`BEAM_REG_THRESH_A, THR_MAX, OKAY, "THRESH_A");
        read_check(`BEAM_REG_THRESH_B, THR_MAX, OKAY, "THRESH_B");
        read_check(`BEAM_REG_CTRL, 0, OKAY, "CTRL");
        read_check(`BEAM_REG_COUNT_A, 0, OKAY, "COUNT_A");
        read_check(`BEAM_REG_COUNT_B, 0, OKAY, "COUNT_B");

        // staged only, no update yet
        write_reg(`BEAM_REG_THRESH_A, 0, OKAY);
        write_reg(`BEAM_REG_THRESH_B, 0, OKAY);
        read_check(`BEAM_REG_THRESH_A, 0, OKAY, "THRESH_A");
        read_check(`BEAM_REG_THRESH_B, 0, OKAY, "THRESH_B");
        for (int i = 0; i < 8; i++) begin
            step_clock();
            check_value("trigger_o", 32'(trigger), 32'h0);
        end

        //////////////////////////////////////////////////////////////////
        // table rows, each held steady for the pipeline latency
        //////////////////////////////////////////////////////////////////
        for (int i = 0; i < NROWS; i++) begin
            va = make_beam(ROWS[i].mode_a, ROWS[i].code_a);
            vb = make_beam(ROWS[i].mode_b, ROWS[i].code_b);
            pa = model_power(va);
            pb = model_power(vb);
            ta = pick_thresh(ROWS[i].tsel_a, ROWS[i].tval_a, pa);
            tb = pick_thresh(ROWS[i].tsel_b, ROWS[i].tval_b, pb);
            exp_trig = {pb > tb, pa > ta};
            write_reg(`BEAM_REG_THRESH_A, ta, OKAY);
            write_reg(`BEAM_REG_THRESH_B, tb, OKAY);
            write_reg(`BEAM_REG_CTRL, 1, OKAY);
            beam_a = va;
            beam_b = vb;
            repeat (`BEAM_PIPE_LAT) step_clock();
            check_value($sformatf("trigger_o row %0d", i), 32'(trigger), 32'(exp_trig));
        end

        // counters: A over 1000 for a known number of clocks, B never
        write_reg(`BEAM_REG_THRESH_A, 1000, OKAY);
        write_reg(`BEAM_REG_THRESH_B, THR_MAX, OKAY);
        write_reg(`BEAM_REG_CTRL, 1, OKAY);
        beam_a = make_beam(CONST, 15);
        beam_b = make_beam(CONST, 15);
        repeat (`BEAM_PIPE_LAT + 3) step_clock();
        write_reg(`BEAM_REG_CTRL, 2, OKAY);
        read_check(`BEAM_REG_COUNT_A, 0, OKAY, "COUNT_A");
        read_check(`BEAM_REG_COUNT_B, 0, OKAY, "COUNT_B");
        beam_a = make_beam(CONST, 0);
        repeat (HOLD_CLKS) step_clock();
        beam_a = make_beam(CONST, 15);
        repeat (`BEAM_PIPE_LAT + 3) step_clock();
        read_check(`BEAM_REG_COUNT_A, HOLD_CLKS, OKAY, "COUNT_A");
        read_check(`BEAM_REG_COUNT_B, 0, OKAY, "COUNT_B");

        // unmapped and unaligned addresses leave every register alone
        read_check(5'h14, 0, SLVERR, "unmapped 0x14");
        write_reg(5'h01, 32'h155, SLVERR);
        write_reg(5'h1C, 32'h2AA, SLVERR);
        read_check(`BEAM_REG_THRESH_A, 1000, OKAY, "THRESH_A");
        read_check(`BEAM_REG_THRESH_B, THR_MAX, OKAY, "THRESH_B");
        read_check(`BEAM_REG_COUNT_A, HOLD_CLKS, OKAY, "COUNT_A");

        write_reg(`BEAM_REG_CTRL, 2, OKAY);
        read_check(`BEAM_REG_COUNT_A, 0, OKAY, "COUNT_A");

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog/beam_axil_regs.sv ====
`timescale 1ns/1ps
`include "beam_params.svh"

module beam_axil_regs import beam_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // write address
    input  logic [`BEAM_AXI_AW-1:0] awaddr_i,
    input  logic                   awvalid_i,
    output logic                   awready_o,
    // write data
    input  logic [31:0]            wdata_i,
    input  logic [3:0]             wstrb_i,
    input  logic                   wvalid_i,
    output logic                   wready_o,
    // write response
    output logic [1:0]             bresp_o,
    output logic                   bvalid_o,
    input  logic                   bready_i,
    // read address
    input  logic [`BEAM_AXI_AW-1:0] araddr_i,
    input  logic                   arvalid_i,
    output logic                   arready_o,
    // read data
    output logic [31:0]            rdata_o,
    output logic [1:0]             rresp_o,
    output logic                   rvalid_o,
    input  logic                   rready_i,
    thresh_cfg_if.regs             cfg
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    thresh_t thresh_a_q;
    thresh_t thresh_b_q;
    logic    update_q;
    logic    clear_q;
    logic    wr_hs;
    logic    rd_hs;

    // ready only rises while both valids are up, so ready alone marks it
    assign wr_hs = awready_o && awvalid_i && wvalid_i;
    assign rd_hs = arready_o && arvalid_i;

    //////////////////////////////////////////////////////////////////////
    // write channel
    //////////////////////////////////////////////////////////////////////

    // byte lanes always written as a full word, wstrb_i has no effect
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            awready_o  <= 1'b0;
            wready_o   <= 1'b0;
            bvalid_o   <= 1'b0;
            thresh_a_q <= '1;
            thresh_b_q <= '1;
            update_q   <= 1'b0;
            clear_q    <= 1'b0;
        end else begin
            // strobes last one cycle
            update_q  <= 1'b0;
            clear_q   <= 1'b0;
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            if (!awready_o && !bvalid_o && awvalid_i && wvalid_i) begin
                awready_o <= 1'b1;
                wready_o  <= 1'b1;
            end
            if (wr_hs) begin
                bvalid_o <= 1'b1;
                bresp_o  <= RESP_OKAY;
                case (awaddr_i)
                    REG_THRESH_A: thresh_a_q <= wdata_i[`BEAM_THRESH_W-1:0];
                    REG_THRESH_B: thresh_b_q <= wdata_i[`BEAM_THRESH_W-1:0];
                    REG_CTRL: begin
                        update_q <= wdata_i[0];
                        clear_q  <= wdata_i[1];
                    end
                    // counters are read-only, write dropped
                    REG_COUNT_A, REG_COUNT_B: ;
                    default: bresp_o <= RESP_SLVERR;
                endcase
            end else if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read channel
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
        end else begin
            arready_o <= !arready_o && !rvalid_o && arvalid_i;
            if (rd_hs) begin
                rvalid_o <= 1'b1;
                rresp_o  <= RESP_OKAY;
                rdata_o  <= '0;
                case (araddr_i)
                    REG_THRESH_A: rdata_o <= 32'(thresh_a_q);
                    REG_THRESH_B: rdata_o <= 32'(thresh_b_q);
                    // CTRL is write-only strobes, reads zero
                    REG_CTRL:     rdata_o <= '0;
                    REG_COUNT_A:  rdata_o <= cfg.count_a;
                    REG_COUNT_B:  rdata_o <= cfg.count_b;
                    default:      rresp_o <= RESP_SLVERR;
                endcase
            end else if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    assign cfg.thresh_a = thresh_a_q;
    assign cfg.thresh_b = thresh_b_q;
    assign cfg.update   = update_q;
    assign cfg.clear    = clear_q;

endmodule

// ==== verilog/beam_pkg.sv ====
`include "beam_params.svh"

package beam_pkg;

    // one offset-binary input code
    typedef logic [`BEAM_NBITS-1:0] code_t;

    // centred sum of 8 channels, range -124..124
    typedef logic signed [7:0] beam_sum_t;

    // square of a centred sum, at most 15376
    typedef logic [13:0] square_t;

    // sum of 8 squares per clock, at most 123008
    typedef logic [16:0] power_t;

    typedef logic [`BEAM_THRESH_W-1:0] thresh_t;
    typedef logic [31:0] count_t;

    // register offsets
    typedef enum logic [`BEAM_AXI_AW-1:0] {
        REG_THRESH_A = `BEAM_REG_THRESH_A,
        REG_THRESH_B = `BEAM_REG_THRESH_B,
        REG_CTRL     = `BEAM_REG_CTRL,
        REG_COUNT_A  = `BEAM_REG_COUNT_A,
        REG_COUNT_B  = `BEAM_REG_COUNT_B
    } reg_off_t;

endpackage

// ==== verilog/beam_power.sv ====
`timescale 1ns/1ps
`include "beam_params.svh"

module beam_power import beam_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [`BEAM_IN_W-1:0] beam_i,
    output power_t                power_o,
    output logic                  power_valid_o
);

    localparam int NCHAN = `BEAM_NCHAN;
    localparam int NSAMP = `BEAM_NSAMP;
    localparam int NBITS = `BEAM_NBITS;
    localparam int SUM_W = $bits(beam_sum_t);
    // the compare stage downstream takes the last clock
    localparam int VLD_W = `BEAM_PIPE_LAT - 1;

    logic [`BEAM_IN_W-1:0] beam_q;
    code_t                 code [NCHAN][NSAMP];
    logic [SUM_W-1:0]      chan_sum [NSAMP];
    beam_sum_t             centred_q [NSAMP];
    logic signed [15:0]    prod [NSAMP];
    square_t               sq_q [NSAMP];
    power_t                acc;
    power_t                power_q;
    logic [VLD_W-1:0]      vld_q;

    //////////////////////////////////////////////////////////////////////
    // stage 1: input register and unpack
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        beam_q <= beam_i;
    end

    // channel c occupies NSAMP*NBITS bits, sample s sits inside it
    always_comb begin
        for (int c = 0; c < NCHAN; c++) begin
            for (int s = 0; s < NSAMP; s++) begin
                code[c][s] = beam_q[NBITS*NSAMP*c + NBITS*s +: NBITS];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2: channel sum per sample, centred to signed
    //////////////////////////////////////////////////////////////////////

    // each code carries a hidden -15.5, so 8 of them are off by 124
    // seed the tree with 4, then dropping 128 is a flip of the msb
    always_comb begin
        for (int s = 0; s < NSAMP; s++) begin
            chan_sum[s] = SUM_W'(4);
            for (int c = 0; c < NCHAN; c++) begin
                chan_sum[s] = chan_sum[s] + SUM_W'(code[c][s]);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int s = 0; s < NSAMP; s++) begin
            centred_q[s] <= {~chan_sum[s][SUM_W-1], chan_sum[s][SUM_W-2:0]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 3 and 4: square, then sum the 8 squares
    //////////////////////////////////////////////////////////////////////

    // |x| <= 124 keeps the square inside 14 bits
    always_comb begin
        for (int s = 0; s < NSAMP; s++) begin
            prod[s] = 16'(centred_q[s]) * 16'(centred_q[s]);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int s = 0; s < NSAMP; s++) begin
            sq_q[s] <= prod[s][13:0];
        end
    end

    always_comb begin
        acc = '0;
        for (int s = 0; s < NSAMP; s++) begin
            acc = acc + power_t'(sq_q[s]);
        end
    end

    always_ff @(posedge clk_i) begin
        power_q <= acc;
    end

    // one bit per stage, filled with ones once out of reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[VLD_W-2:0], 1'b1};
        end
    end

    assign power_o       = power_q;
    assign power_valid_o = vld_q[VLD_W-1];

endmodule

// ==== verilog/dual_beam_trigger.sv ====
`timescale 1ns/1ps
`include "beam_params.svh"

module dual_beam_trigger import beam_pkg::*; (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [`BEAM_IN_W-1:0]   beam_a_i,
    input  logic [`BEAM_IN_W-1:0]   beam_b_i,
    // AXI4-Lite slave
    input  logic [`BEAM_AXI_AW-1:0] s_axil_awaddr_i,
    input  logic                    s_axil_awvalid_i,
    output logic                    s_axil_awready_o,
    input  logic [31:0]             s_axil_wdata_i,
    input  logic [3:0]              s_axil_wstrb_i,
    input  logic                    s_axil_wvalid_i,
    output logic                    s_axil_wready_o,
    output logic [1:0]              s_axil_bresp_o,
    output logic                    s_axil_bvalid_o,
    input  logic                    s_axil_bready_i,
    input  logic [`BEAM_AXI_AW-1:0] s_axil_araddr_i,
    input  logic                    s_axil_arvalid_i,
    output logic                    s_axil_arready_o,
    output logic [31:0]             s_axil_rdata_o,
    output logic [1:0]              s_axil_rresp_o,
    output logic                    s_axil_rvalid_o,
    input  logic                    s_axil_rready_i,
    // bit 0 beam A, bit 1 beam B
    output logic [1:0]              trigger_o
);

    power_t power_a;
    power_t power_b;
    logic   power_valid;

    thresh_cfg_if cfg_if ();

    // beam B valid matches beam A, left open
    beam_power u_beam_a (
        .clk_i(clk_i), .rst_i(rst_i), .beam_i(beam_a_i),
        .power_o(power_a), .power_valid_o(power_valid)
    );

    beam_power u_beam_b (
        .clk_i(clk_i), .rst_i(rst_i), .beam_i(beam_b_i),
        .power_o(power_b), .power_valid_o()
    );

    threshold_detect u_detect (
        .clk_i(clk_i), .rst_i(rst_i),
        .power_a_i(power_a), .power_b_i(power_b), .power_valid_i(power_valid),
        .cfg(cfg_if.detect), .trigger_o(trigger_o)
    );

    beam_axil_regs u_regs (
        .clk_i(clk_i), .rst_i(rst_i),
        .awaddr_i(s_axil_awaddr_i), .awvalid_i(s_axil_awvalid_i),
        .awready_o(s_axil_awready_o),
        .wdata_i(s_axil_wdata_i), .wstrb_i(s_axil_wstrb_i),
        .wvalid_i(s_axil_wvalid_i), .wready_o(s_axil_wready_o),
        .bresp_o(s_axil_bresp_o), .bvalid_o(s_axil_bvalid_o), .bready_i(s_axil_bready_i),
        .araddr_i(s_axil_araddr_i), .arvalid_i(s_axil_arvalid_i),
        .arready_o(s_axil_arready_o),
        .rdata_o(s_axil_rdata_o), .rresp_o(s_axil_rresp_o),
        .rvalid_o(s_axil_rvalid_o), .rready_i(s_axil_rready_i),
        .cfg(cfg_if.regs)
    );

endmodule

// ==== verilog/thresh_cfg_if.sv ====
`timescale 1ns/1ps

interface thresh_cfg_if import beam_pkg::*; ();

    // staged thresholds, copied to active on update
    thresh_t thresh_a;
    thresh_t thresh_b;
    // single-cycle strobes from CTRL writes
    logic    update;
    logic    clear;
    // trigger counters back to the register block
    count_t  count_a;
    count_t  count_b;

    modport regs (
        output thresh_a, thresh_b, update, clear,
        input  count_a, count_b
    );

    modport detect (
        input  thresh_a, thresh_b, update, clear,
        output count_a, count_b
    );

endinterface

// ==== verilog/threshold_detect.sv ====
`timescale 1ns/1ps

module threshold_detect import beam_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  power_t     power_a_i,
    input  power_t     power_b_i,
    // both beams share timing, so one valid serves both
    input  logic       power_valid_i,
    thresh_cfg_if.detect cfg,
    // bit 0 is beam A
    output logic [1:0] trigger_o
);

    thresh_t act_a_q;
    thresh_t act_b_q;
    count_t  cnt_a_q;
    count_t  cnt_b_q;

    // active thresholds, all ones so nothing fires out of reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            act_a_q <= '1;
            act_b_q <= '1;
        end else if (cfg.update) begin
            act_a_q <= cfg.thresh_a;
            act_b_q <= cfg.thresh_b;
        end
    end

    // strictly greater than, registered
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            trigger_o <= 2'b00;
        end else begin
            trigger_o[0] <= power_valid_i && (power_a_i > act_a_q);
            trigger_o[1] <= power_valid_i && (power_b_i > act_b_q);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // trigger counters
    //////////////////////////////////////////////////////////////////////

    // one count per clock with the trigger high, wraps at 2^32
    always_ff @(posedge clk_i) begin
        if (rst_i || cfg.clear) begin
            cnt_a_q <= '0;
            cnt_b_q <= '0;
        end else begin
            cnt_a_q <= cnt_a_q + count_t'(trigger_o[0]);
            cnt_b_q <= cnt_b_q + count_t'(trigger_o[1]);
        end
    end

    assign cfg.count_a = cnt_a_q;
    assign cfg.count_b = cnt_b_q;

endmodule
